/* verilog/msrh_defs.svh */
// shared width, depth and address constants for the L2 port
// covers address and line widths, tag and source id widths,
// RAM window, RAM read latency and FIFO depth
`ifndef MSRH_DEFS_SVH
`define MSRH_DEFS_SVH

// address and line geometry
`define MSRH_PADDR_W 32
`define MSRH_L2_DATA_W 64
`define MSRH_L2_BE_W (`MSRH_L2_DATA_W / 8)

// request identification
`define MSRH_L2_CMD_TAG_W 4
`define MSRH_L2_SRC_W 2

// behavioral RAM window and timing
`define MSRH_L2_RAM_BASE 32'h8000_0000
`define MSRH_L2_RAM_WORDS 256
`define MSRH_L2_RD_LAT 4

// request FIFO between arbiter and RAM
`define MSRH_L2_FIFO_DEPTH 2

`endif

/* verilog/riscv_pkg.sv */
// architectural types shared by the L2 port
// physical address type
`include "msrh_defs.svh"

package riscv_pkg;

  // one physical address word
  typedef logic [`MSRH_PADDR_W-1:0] paddr_t;

endpackage

/* verilog/msrh_lsu_pkg.sv */
// L2 port types
// command encoding, requester source id,
// request and response payload structs
`include "msrh_defs.svh"

package msrh_lsu_pkg;

  typedef enum logic [1:0] {
    M_XRD = 2'd0,
    M_XWR = 2'd1
  } mem_cmd_t;

  // encoding order is also the arbitration priority
  typedef enum logic [`MSRH_L2_SRC_W-1:0] {
    SRC_L1D = 2'd0,
    SRC_PTW = 2'd1,
    SRC_IC  = 2'd2,
    SRC_ELF = 2'd3
  } l2_src_t;

  typedef struct packed {
    mem_cmd_t                        cmd;
    riscv_pkg::paddr_t               addr;
    l2_src_t                         src;
    logic [`MSRH_L2_CMD_TAG_W-1:0]   tag;
    logic [`MSRH_L2_DATA_W-1:0]      data;
    logic [`MSRH_L2_BE_W-1:0]        byte_en;
  } l2_req_t;

  // the tag is the requester's own, src picks the return port
  typedef struct packed {
    l2_src_t                         src;
    logic [`MSRH_L2_CMD_TAG_W-1:0]   tag;
    logic [`MSRH_L2_DATA_W-1:0]      data;
  } l2_resp_t;

endpackage

/* verilog/msrh_l2_if.sv */
// L2 channel bundle
// one request and one response valid/ready channel,
// with master, slave and monitor views
`timescale 1ns/1ps
`include "msrh_defs.svh"

interface msrh_l2_if;

  logic                   req_valid;
  logic                   req_ready;
  msrh_lsu_pkg::l2_req_t  req;

  logic                   resp_valid;
  logic                   resp_ready;
  msrh_lsu_pkg::l2_resp_t resp;

  modport master (
    output req_valid, req, resp_ready,
    input  req_ready, resp_valid, resp
  );

  modport slave (
    input  req_valid, req, resp_ready,
    output req_ready, resp_valid, resp
  );

  modport monitor (
    input req_valid, req_ready, req,
    input resp_valid, resp_ready, resp
  );

endinterface

/* verilog/msrh_l2_fifo.sv */
// valid/ready FIFO with a payload type parameter
// circular buffer with pointers and an occupancy count
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_fifo #(
  parameter type T     = msrh_lsu_pkg::l2_req_t,
  parameter int  DEPTH = `MSRH_L2_FIFO_DEPTH
) (
  input  logic i_clk,
  input  logic i_msrh_reset_n,

  input  logic i_push_valid,
  input  T     i_push_data,
  output logic o_push_ready,

  output logic o_pop_valid,
  output T     o_pop_data,
  input  logic i_pop_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_push;
  logic             w_pop;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign w_push       = i_push_valid & o_push_ready;
  assign w_pop        = o_pop_valid & i_pop_ready;
  assign o_push_ready = r_count != CNT_W'(DEPTH);
  assign o_pop_valid  = r_count != '0;
  assign o_pop_data   = r_mem[r_rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= next_ptr(r_wr_ptr);
      end
      if (w_pop) begin
        r_rd_ptr <= next_ptr(r_rd_ptr);
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wr_ptr] <= i_push_data;
    end
  end

  // equal pointers mean the buffer is empty or full,
  // so a push never lands on an entry still waiting to pop
  a_no_push_full : assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      (r_wr_ptr == r_rd_ptr) |-> (r_count == '0 || r_count == CNT_W'(DEPTH)));

endmodule

/* verilog/msrh_l2_req_arb.sv */
// fixed-priority L2 request arbiter
// L1D over PTW over IC over ELF, one grant per cycle,
// the granted request is tagged with its source id
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_req_arb (
  input  logic                                i_clk,
  input  logic                                i_msrh_reset_n,

  input  logic                                i_l1d_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t              i_l1d_req_cmd,
  input  riscv_pkg::paddr_t                   i_l1d_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0]       i_l1d_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]          i_l1d_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]            i_l1d_req_byte_en,
  output logic                                o_l1d_req_ready,

  input  logic                                i_ptw_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t              i_ptw_req_cmd,
  input  riscv_pkg::paddr_t                   i_ptw_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0]       i_ptw_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]          i_ptw_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]            i_ptw_req_byte_en,
  output logic                                o_ptw_req_ready,

  input  logic                                i_ic_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t              i_ic_req_cmd,
  input  riscv_pkg::paddr_t                   i_ic_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0]       i_ic_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]          i_ic_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]            i_ic_req_byte_en,
  output logic                                o_ic_req_ready,

  input  logic                                i_elf_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t              i_elf_req_cmd,
  input  riscv_pkg::paddr_t                   i_elf_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0]       i_elf_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]          i_elf_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]            i_elf_req_byte_en,
  output logic                                o_elf_req_ready,

  msrh_l2_if.master                           o_arb
);

  import riscv_pkg::*;
  import msrh_lsu_pkg::*;

  // ports gathered by source id, index 0 is the highest priority
  logic [3:0]                    w_valid;
  mem_cmd_t                      w_cmd     [4];
  paddr_t                        w_addr    [4];
  logic [`MSRH_L2_CMD_TAG_W-1:0] w_tag     [4];
  logic [`MSRH_L2_DATA_W-1:0]    w_data    [4];
  logic [`MSRH_L2_BE_W-1:0]      w_byte_en [4];
  l2_src_t                       w_sel;
  logic [3:0]                    w_ready;

  assign w_valid   = {i_elf_req_valid, i_ic_req_valid, i_ptw_req_valid, i_l1d_req_valid};
  assign w_cmd     = '{i_l1d_req_cmd, i_ptw_req_cmd, i_ic_req_cmd, i_elf_req_cmd};
  assign w_addr    = '{i_l1d_req_addr, i_ptw_req_addr, i_ic_req_addr, i_elf_req_addr};
  assign w_tag     = '{i_l1d_req_tag, i_ptw_req_tag, i_ic_req_tag, i_elf_req_tag};
  assign w_data    = '{i_l1d_req_data, i_ptw_req_data, i_ic_req_data, i_elf_req_data};
  assign w_byte_en = '{i_l1d_req_byte_en, i_ptw_req_byte_en,
                       i_ic_req_byte_en, i_elf_req_byte_en};

  // ELF is the default grant, a lower index overrides it
  always_comb begin
    w_sel = SRC_ELF;
    for (int i = 2; i >= 0; i--) begin
      if (w_valid[i]) begin
        w_sel = l2_src_t'(i);
      end
    end
  end

  assign o_arb.req_valid = |w_valid;
  assign o_arb.req = '{cmd:     w_cmd[w_sel],
                       addr:    w_addr[w_sel],
                       src:     w_sel,
                       tag:     w_tag[w_sel],
                       data:    w_data[w_sel],
                       byte_en: w_byte_en[w_sel]};
  // nothing returns on this hop
  assign o_arb.resp_ready = 1'b1;

  // only the granted port sees the FIFO space
  assign w_ready         = o_arb.req_ready ? (4'b0001 << w_sel) : 4'b0000;
  assign o_l1d_req_ready = w_ready[0];
  assign o_ptw_req_ready = w_ready[1];
  assign o_ic_req_ready  = w_ready[2];
  assign o_elf_req_ready = w_ready[3];

  // at most one ready, and with requests pending it goes to a requesting
  // port that no higher-priority request overrides
  a_ready_onehot : assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      $onehot0({o_l1d_req_ready, o_ptw_req_ready, o_ic_req_ready, o_elf_req_ready}) &&
      ((w_ready == 4'b0000) || (w_valid == 4'b0000) ||
       ($onehot(w_ready & w_valid) &&
        ((w_valid & (w_ready - 4'b0001)) == 4'b0000))));

endmodule

/* verilog/msrh_l2_ram.sv */
// behavioral L2 RAM
// byte-enable writes, fixed-latency read pipeline,
// response queue guarded by read credits
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_ram (
  input  logic      i_clk,
  input  logic      i_msrh_reset_n,
  msrh_l2_if.slave  s_req
);

  import msrh_lsu_pkg::*;

  localparam int LAT       = `MSRH_L2_RD_LAT;
  localparam int LINE_B    = `MSRH_L2_BE_W;
  localparam int OFF_W     = $clog2(LINE_B);
  localparam int IDX_W     = $clog2(`MSRH_L2_RAM_WORDS);
  localparam int RAM_BYTES = `MSRH_L2_RAM_WORDS * LINE_B;
  localparam int CNT_W     = $clog2(LAT + 1);

  logic [`MSRH_L2_DATA_W-1:0] r_ram [`MSRH_L2_RAM_WORDS];

  logic [`MSRH_PADDR_W-1:0] w_offset;
  logic [IDX_W-1:0]         w_idx;
  logic                     w_is_rd;
  logic                     w_accept;
  logic                     w_rd_acc;
  logic                     w_wr_acc;
  l2_resp_t                 w_rd_resp;

  logic [LAT-1:0]           r_pipe_valid;
  l2_resp_t                 r_pipe_resp [LAT];
  logic [CNT_W-1:0]         r_credit;
  logic                     w_q_push_ready;
  logic                     w_resp_pop;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------
  assign w_offset = s_req.req.addr - `MSRH_L2_RAM_BASE;
  assign w_idx    = w_offset[OFF_W +: IDX_W];
  assign w_is_rd  = s_req.req.cmd == M_XRD;

  // reads wait for a credit, writes pass freely
  assign s_req.req_ready = !w_is_rd || (r_credit < CNT_W'(LAT));
  assign w_accept = s_req.req_valid & s_req.req_ready;
  assign w_rd_acc = w_accept & w_is_rd;
  assign w_wr_acc = w_accept & (s_req.req.cmd == M_XWR);

  always_ff @(posedge i_clk) begin
    if (w_wr_acc) begin
      for (int b = 0; b < LINE_B; b++) begin
        if (s_req.req.byte_en[b]) begin
          r_ram[w_idx][b*8 +: 8] <= s_req.req.data[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // read pipeline and response queue
  // ------------------------------------------------------------
  assign w_rd_resp = '{src: s_req.req.src, tag: s_req.req.tag, data: r_ram[w_idx]};

  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      r_pipe_valid <= '0;
    end else begin
      r_pipe_valid <= {r_pipe_valid[LAT-2:0], w_rd_acc};
    end
  end

  always_ff @(posedge i_clk) begin
    r_pipe_resp[0] <= w_rd_resp;
    for (int s = 1; s < LAT; s++) begin
      r_pipe_resp[s] <= r_pipe_resp[s-1];
    end
  end

  msrh_l2_fifo #(
    .T     (l2_resp_t),
    .DEPTH (LAT + 1)
  ) resp_q (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_push_valid   (r_pipe_valid[LAT-1]),
    .i_push_data    (r_pipe_resp[LAT-1]),
    .o_push_ready   (w_q_push_ready),
    .o_pop_valid    (s_req.resp_valid),
    .o_pop_data     (s_req.resp),
    .i_pop_ready    (s_req.resp_ready)
  );

  assign w_resp_pop = s_req.resp_valid & s_req.resp_ready;

  // a credit is held from read acceptance until its response leaves
  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      r_credit <= '0;
    end else begin
      case ({w_rd_acc, w_resp_pop})
        2'b10:   r_credit <= r_credit + 1'b1;
        2'b01:   r_credit <= r_credit - 1'b1;
        default: r_credit <= r_credit;
      endcase
    end
  end

  a_addr_in_window : assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      w_accept |-> (w_offset < RAM_BYTES));

  // credits keep the queue from overflowing under back-pressure
  a_queue_has_room : assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      r_pipe_valid[LAT-1] |-> w_q_push_ready);

endmodule

/* verilog/msrh_l2_resp_router.sv */
// L2 response router
// steers each read response to L1D, PTW or IC by source id
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_resp_router (
  msrh_l2_if.master                     s_resp,

  output logic                          o_l1d_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_l1d_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_l1d_resp_data,
  input  logic                          i_l1d_resp_ready,

  output logic                          o_ptw_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_ptw_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_ptw_resp_data,
  input  logic                          i_ptw_resp_ready,

  output logic                          o_ic_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_ic_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_ic_resp_data,
  input  logic                          i_ic_resp_ready
);

  import msrh_lsu_pkg::*;

  assign o_l1d_resp_valid = s_resp.resp_valid && (s_resp.resp.src == SRC_L1D);
  assign o_ptw_resp_valid = s_resp.resp_valid && (s_resp.resp.src == SRC_PTW);
  assign o_ic_resp_valid  = s_resp.resp_valid && (s_resp.resp.src == SRC_IC);

  // tag and data go to all ports, valid picks the receiver
  assign o_l1d_resp_tag  = s_resp.resp.tag;
  assign o_l1d_resp_data = s_resp.resp.data;
  assign o_ptw_resp_tag  = s_resp.resp.tag;
  assign o_ptw_resp_data = s_resp.resp.data;
  assign o_ic_resp_tag   = s_resp.resp.tag;
  assign o_ic_resp_data  = s_resp.resp.data;

  always_comb begin
    case (s_resp.resp.src)
      SRC_L1D: s_resp.resp_ready = i_l1d_resp_ready;
      SRC_PTW: s_resp.resp_ready = i_ptw_resp_ready;
      SRC_IC:  s_resp.resp_ready = i_ic_resp_ready;
      default: s_resp.resp_ready = 1'b0;
    endcase
  end

  // ELF only writes, so no read response may be tagged with it
  always_comb begin
    if (s_resp.resp_valid) begin
      a_no_elf_resp : assert (s_resp.resp.src != SRC_ELF);
    end
  end

endmodule

/* verilog/msrh_l2_subsys.sv */
// L2 memory port subsystem top
// arbiter, request FIFO, behavioral RAM and response router
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_subsys (
  input  logic                          i_clk,
  input  logic                          i_msrh_reset_n,

  input  logic                          i_l1d_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t        i_l1d_req_cmd,
  input  riscv_pkg::paddr_t             i_l1d_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0] i_l1d_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]    i_l1d_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]      i_l1d_req_byte_en,
  output logic                          o_l1d_req_ready,
  output logic                          o_l1d_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_l1d_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_l1d_resp_data,
  input  logic                          i_l1d_resp_ready,

  input  logic                          i_ptw_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t        i_ptw_req_cmd,
  input  riscv_pkg::paddr_t             i_ptw_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0] i_ptw_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]    i_ptw_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]      i_ptw_req_byte_en,
  output logic                          o_ptw_req_ready,
  output logic                          o_ptw_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_ptw_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_ptw_resp_data,
  input  logic                          i_ptw_resp_ready,

  input  logic                          i_ic_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t        i_ic_req_cmd,
  input  riscv_pkg::paddr_t             i_ic_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0] i_ic_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]    i_ic_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]      i_ic_req_byte_en,
  output logic                          o_ic_req_ready,
  output logic                          o_ic_resp_valid,
  output logic [`MSRH_L2_CMD_TAG_W-1:0] o_ic_resp_tag,
  output logic [`MSRH_L2_DATA_W-1:0]    o_ic_resp_data,
  input  logic                          i_ic_resp_ready,

  // ELF loader only writes, so it has no response path
  input  logic                          i_elf_req_valid,
  input  msrh_lsu_pkg::mem_cmd_t        i_elf_req_cmd,
  input  riscv_pkg::paddr_t             i_elf_req_addr,
  input  logic [`MSRH_L2_CMD_TAG_W-1:0] i_elf_req_tag,
  input  logic [`MSRH_L2_DATA_W-1:0]    i_elf_req_data,
  input  logic [`MSRH_L2_BE_W-1:0]      i_elf_req_byte_en,
  output logic                          o_elf_req_ready
);

  import msrh_lsu_pkg::*;

  msrh_l2_if arb_if ();
  msrh_l2_if ram_if ();

  // the arbiter hop carries requests only
  assign arb_if.resp_valid = 1'b0;
  assign arb_if.resp       = '0;

  msrh_l2_req_arb req_arb (
    .i_clk             (i_clk),
    .i_msrh_reset_n    (i_msrh_reset_n),
    .i_l1d_req_valid   (i_l1d_req_valid),
    .i_l1d_req_cmd     (i_l1d_req_cmd),
    .i_l1d_req_addr    (i_l1d_req_addr),
    .i_l1d_req_tag     (i_l1d_req_tag),
    .i_l1d_req_data    (i_l1d_req_data),
    .i_l1d_req_byte_en (i_l1d_req_byte_en),
    .o_l1d_req_ready   (o_l1d_req_ready),
    .i_ptw_req_valid   (i_ptw_req_valid),
    .i_ptw_req_cmd     (i_ptw_req_cmd),
    .i_ptw_req_addr    (i_ptw_req_addr),
    .i_ptw_req_tag     (i_ptw_req_tag),
    .i_ptw_req_data    (i_ptw_req_data),
    .i_ptw_req_byte_en (i_ptw_req_byte_en),
    .o_ptw_req_ready   (o_ptw_req_ready),
    .i_ic_req_valid    (i_ic_req_valid),
    .i_ic_req_cmd      (i_ic_req_cmd),
    .i_ic_req_addr     (i_ic_req_addr),
    .i_ic_req_tag      (i_ic_req_tag),
    .i_ic_req_data     (i_ic_req_data),
    .i_ic_req_byte_en  (i_ic_req_byte_en),
    .o_ic_req_ready    (o_ic_req_ready),
    .i_elf_req_valid   (i_elf_req_valid),
    .i_elf_req_cmd     (i_elf_req_cmd),
    .i_elf_req_addr    (i_elf_req_addr),
    .i_elf_req_tag     (i_elf_req_tag),
    .i_elf_req_data    (i_elf_req_data),
    .i_elf_req_byte_en (i_elf_req_byte_en),
    .o_elf_req_ready   (o_elf_req_ready),
    .o_arb             (arb_if.master)
  );

  msrh_l2_fifo #(
    .T     (l2_req_t),
    .DEPTH (`MSRH_L2_FIFO_DEPTH)
  ) req_fifo (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_push_valid   (arb_if.req_valid),
    .i_push_data    (arb_if.req),
    .o_push_ready   (arb_if.req_ready),
    .o_pop_valid    (ram_if.req_valid),
    .o_pop_data     (ram_if.req),
    .i_pop_ready    (ram_if.req_ready)
  );

  msrh_l2_ram l2_ram (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .s_req          (ram_if.slave)
  );

  msrh_l2_resp_router resp_router (
    .s_resp           (ram_if.master),
    .o_l1d_resp_valid (o_l1d_resp_valid),
    .o_l1d_resp_tag   (o_l1d_resp_tag),
    .o_l1d_resp_data  (o_l1d_resp_data),
    .i_l1d_resp_ready (i_l1d_resp_ready),
    .o_ptw_resp_valid (o_ptw_resp_valid),
    .o_ptw_resp_tag   (o_ptw_resp_tag),
    .o_ptw_resp_data  (o_ptw_resp_data),
    .i_ptw_resp_ready (i_ptw_resp_ready),
    .o_ic_resp_valid  (o_ic_resp_valid),
    .o_ic_resp_tag    (o_ic_resp_tag),
    .o_ic_resp_data   (o_ic_resp_data),
    .i_ic_resp_ready  (i_ic_resp_ready)
  );

endmodule

/* test/msrh_l2_tb.sv */
// directed testbench for the L2 memory port subsystem
// clock, reset, watchdog, shadow memory model, response monitor
// and one task per test
`timescale 1ns/1ps
`include "msrh_defs.svh"

module msrh_l2_tb;

  import riscv_pkg::*;
  import msrh_lsu_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int NUM_TESTS     = 6;
  localparam int TEST_BUDGET   = 2000;
  localparam int LINE_B        = `MSRH_L2_BE_W;
  localparam int P_L1D         = 0;
  localparam int P_PTW         = 1;
  localparam int P_IC          = 2;
  localparam int P_ELF         = 3;

  typedef logic [`MSRH_L2_DATA_W-1:0]    line_t;
  typedef logic [`MSRH_L2_CMD_TAG_W-1:0] tag_t;
  typedef logic [`MSRH_L2_BE_W-1:0]      be_t;

  typedef struct packed {
    paddr_t addr;
    tag_t   tag;
    line_t  data;
    be_t    byte_en;
  } port_req_t;

  typedef struct packed {
    tag_t  tag;
    line_t data;
  } exp_t;

  // DUT ports, named as on the top level
  logic     i_clk;
  logic     i_msrh_reset_n;
  logic     i_l1d_req_valid, i_ptw_req_valid, i_ic_req_valid, i_elf_req_valid;
  mem_cmd_t i_l1d_req_cmd, i_ptw_req_cmd, i_ic_req_cmd, i_elf_req_cmd;
  paddr_t   i_l1d_req_addr, i_ptw_req_addr, i_ic_req_addr, i_elf_req_addr;
  tag_t     i_l1d_req_tag, i_ptw_req_tag, i_ic_req_tag, i_elf_req_tag;
  line_t    i_l1d_req_data, i_ptw_req_data, i_ic_req_data, i_elf_req_data;
  be_t      i_l1d_req_byte_en, i_ptw_req_byte_en, i_ic_req_byte_en, i_elf_req_byte_en;
  logic     o_l1d_req_ready, o_ptw_req_ready, o_ic_req_ready, o_elf_req_ready;
  logic     o_l1d_resp_valid, o_ptw_resp_valid, o_ic_resp_valid;
  tag_t     o_l1d_resp_tag, o_ptw_resp_tag, o_ic_resp_tag;
  line_t    o_l1d_resp_data, o_ptw_resp_data, o_ic_resp_data;
  logic     i_l1d_resp_ready, i_ptw_resp_ready, i_ic_resp_ready;

  // per-port views indexed by source id
  mem_cmd_t   drv_cmd [4];
  port_req_t  drv [4];
  logic [3:0] drv_valid;
  logic [3:0] rdy;
  logic [2:0] rsp_valid;
  logic [2:0] rsp_ready;
  tag_t       rsp_tag [3];
  line_t      rsp_data [3];

  // shadow memory and expected read responses per port
  line_t  shadow [`MSRH_L2_RAM_WORDS];
  exp_t   exp_q [3][$];
  int     last_rx [3];
  int     cycle = 0;
  integer seed;
  string  cur_test;

  assign {i_elf_req_valid, i_ic_req_valid, i_ptw_req_valid, i_l1d_req_valid} = drv_valid;
  assign i_l1d_req_cmd = drv_cmd[0];
  assign i_ptw_req_cmd = drv_cmd[1];
  assign i_ic_req_cmd  = drv_cmd[2];
  assign i_elf_req_cmd = drv_cmd[3];
  assign {i_l1d_req_addr, i_l1d_req_tag, i_l1d_req_data, i_l1d_req_byte_en} = drv[0];
  assign {i_ptw_req_addr, i_ptw_req_tag, i_ptw_req_data, i_ptw_req_byte_en} = drv[1];
  assign {i_ic_req_addr, i_ic_req_tag, i_ic_req_data, i_ic_req_byte_en}     = drv[2];
  assign {i_elf_req_addr, i_elf_req_tag, i_elf_req_data, i_elf_req_byte_en} = drv[3];
  assign rdy = {o_elf_req_ready, o_ic_req_ready, o_ptw_req_ready, o_l1d_req_ready};
  assign rsp_valid = {o_ic_resp_valid, o_ptw_resp_valid, o_l1d_resp_valid};
  assign {i_ic_resp_ready, i_ptw_resp_ready, i_l1d_resp_ready} = rsp_ready;
  assign rsp_tag  = '{o_l1d_resp_tag, o_ptw_resp_tag, o_ic_resp_tag};
  assign rsp_data = '{o_l1d_resp_data, o_ptw_resp_data, o_ic_resp_data};

  msrh_l2_subsys msrh_l2_subsys_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
  end

  // ------------------------------------------------------------
  // checking helpers and the memory model
  // ------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string what, input line_t exp, input line_t act);
    assert (act === exp) else begin
      abort_run($sformatf("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
                          cur_test, what, exp, act));
    end
  endtask

  task automatic check_true(input logic cond, input string reason);
    assert (cond) else begin
      abort_run(reason);
    end
  endtask

  function automatic int line_idx(input paddr_t addr);
    return int'((addr - `MSRH_L2_RAM_BASE) / LINE_B);
  endfunction

  function automatic paddr_t line_addr(input int idx);
    return `MSRH_L2_RAM_BASE + paddr_t'(idx * LINE_B);
  endfunction

  // bytes with byte_en set take the new data
  function automatic line_t merge_bytes(input line_t old, input line_t data, input be_t be);
    line_t res;
    res = old;
    for (int b = 0; b < LINE_B; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic record_accept(input int p, input mem_cmd_t cmd, input port_req_t r);
    int   idx;
    exp_t e;
    idx = line_idx(r.addr);
    if (cmd == M_XWR) begin
      shadow[idx] = merge_bytes(shadow[idx], r.data, r.byte_en);
    end else begin
      check_true(p != P_ELF, "the ELF port issued a read but has no response path");
      e.tag  = r.tag;
      e.data = shadow[idx];
      exp_q[p].push_back(e);
    end
  endtask

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic send_req(input int p, input mem_cmd_t cmd, input int idx,
                          input tag_t tag, input line_t data, input be_t be);
    drv_cmd[p]   = cmd;
    drv[p]       = '{addr: line_addr(idx), tag: tag, data: data, byte_en: be};
    drv_valid[p] = 1'b1;
    @(posedge i_clk);
    while (!rdy[p]) begin
      @(posedge i_clk);
    end
    record_accept(p, cmd, drv[p]);
    @(negedge i_clk);
    drv_valid[p] = 1'b0;
  endtask

  task automatic take_resp(input int p, input tag_t tag, input line_t data);
    exp_t e;
    check_true(exp_q[p].size() > 0,
               $sformatf("%s: response on port %0d with no read outstanding", cur_test, p));
    e = exp_q[p].pop_front();
    check_eq("response tag", line_t'(e.tag), line_t'(tag));
    check_eq("response data", e.data, data);
    last_rx[p] = cycle;
  endtask

  always @(posedge i_clk) begin
    check_true($countones(rsp_valid) <= 1, "more than one response port valid at once");
    for (int p = 0; p < 3; p++) begin
      if (rsp_valid[p] && rsp_ready[p]) begin
        take_resp(p, rsp_tag[p], rsp_data[p]);
      end
    end
  end

  // every expected read answered, then no port may see a stray response
  task automatic wait_drain();
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
      @(negedge i_clk);
    end
    repeat (`MSRH_L2_RD_LAT + 2) begin
      @(negedge i_clk);
      check_eq("resp_valid after all reads answered", '0, line_t'(rsp_valid));
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_reset();
    cur_test = "test_reset";
    i_msrh_reset_n = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge i_clk);
      check_eq("resp_valid during reset", '0, line_t'(rsp_valid));
    end
    i_msrh_reset_n = 1'b0;
    repeat (2) begin
      @(negedge i_clk);
      check_eq("resp_valid after reset", '0, line_t'(rsp_valid));
    end
    // idle ports, so the grant falls to ELF
    check_eq("req_ready with idle ports", line_t'(4'b1000), line_t'(rdy));
  endtask

  task automatic test_load_and_fetch();
    cur_test = "test_load_and_fetch";
    for (int i = 0; i < 4; i++) begin
      send_req(P_ELF, M_XWR, 16 + i, '0, {32'h1000_0000 + 32'(i), 32'hcafe_0000 + 32'(i)}, '1);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(P_IC, M_XRD, 16 + i, tag_t'(i + 5), '0, '0);
    end
    wait_drain();
  endtask

  task automatic test_byte_enable();
    cur_test = "test_byte_enable";
    send_req(P_L1D, M_XWR, 40, 4'h1, 64'h0011_2233_4455_6677, '1);
    send_req(P_L1D, M_XWR, 40, 4'h2, 64'haaaa_aaaa_aaaa_aaaa, 8'b1010_0101);
    check_eq("merged model line", 64'haa11_aa33_44aa_66aa, shadow[40]);
    send_req(P_PTW, M_XRD, 40, 4'h9, '0, '0);
    wait_drain();
  endtask

  task automatic test_priority();
    cur_test = "test_priority";
    fork
      send_req(P_L1D, M_XRD, 16, 4'h1, '0, '0);
      send_req(P_PTW, M_XRD, 17, 4'h2, '0, '0);
      send_req(P_IC, M_XRD, 18, 4'h3, '0, '0);
    join
    wait_drain();
    check_true(last_rx[P_L1D] <= last_rx[P_PTW], "PTW response came before the L1D one");
    check_true(last_rx[P_PTW] <= last_rx[P_IC], "IC response came before the PTW one");
  endtask

  task automatic test_backpressure();
    cur_test = "test_backpressure";
    rsp_ready[P_IC] = 1'b0;
    fork
      for (int i = 0; i < 6; i++) begin
        send_req(P_IC, M_XRD, 16 + (i % 4), tag_t'(i + 8), '0, '0);
      end
      begin
        // a held response must be the oldest outstanding read
        repeat (16) begin
          @(negedge i_clk);
          if (rsp_valid[P_IC]) begin
            check_eq("stalled IC response tag", line_t'(exp_q[P_IC][0].tag),
                     line_t'(rsp_tag[P_IC]));
            check_eq("stalled IC response data", exp_q[P_IC][0].data, rsp_data[P_IC]);
          end
        end
        check_eq("IC resp_valid while stalled", line_t'(1), line_t'(rsp_valid[P_IC]));
        rsp_ready[P_IC] = 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic test_random();
    int       pool [8];
    int       p;
    mem_cmd_t cmd;
    cur_test = "test_random";
    // fill a random set of lines so every read has known data
    for (int i = 0; i < 8; i++) begin
      pool[i] = int'($unsigned($random(seed)) % `MSRH_L2_RAM_WORDS);
      send_req(P_ELF, M_XWR, pool[i], '0, {$random(seed), $random(seed)}, '1);
    end
    for (int n = 0; n < 32; n++) begin
      p   = int'($unsigned($random(seed)) % 4);
      cmd = (p == P_ELF || $random(seed) % 2 == 0) ? M_XWR : M_XRD;
      send_req(p, cmd, pool[$unsigned($random(seed)) % 8], tag_t'(n),
               {$random(seed), $random(seed)}, be_t'($random(seed)));
    end
    wait_drain();
  endtask

  initial begin
    #(NUM_TESTS * TEST_BUDGET);
    abort_run($sformatf("timeout: %s did not finish within %0d ns",
                        cur_test, NUM_TESTS * TEST_BUDGET));
  end

  initial begin
    seed           = 47;
    cur_test       = "init";
    i_msrh_reset_n = 1'b1;
    drv_valid      = '0;
    rsp_ready      = '1;
    last_rx        = '{0, 0, 0};
    for (int i = 0; i < 4; i++) begin
      drv_cmd[i] = M_XRD;
      drv[i]     = '0;
    end
    test_reset();
    test_load_and_fetch();
    test_byte_enable();
    test_priority();
    test_backpressure();
    test_random();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/riscv_pkg.sv
verilog/msrh_lsu_pkg.sv
verilog/msrh_l2_if.sv
verilog/msrh_l2_fifo.sv
verilog/msrh_l2_req_arb.sv
verilog/msrh_l2_ram.sv
verilog/msrh_l2_resp_router.sv
verilog/msrh_l2_subsys.sv
test/msrh_l2_tb.sv

/* Makefile */
# Verilator build and run for the L2 memory port testbench

VERILATOR ?= verilator
TOP       ?= msrh_l2_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
